//--- src/display_pkg.sv
package display_pkg;

    // screen coordinate, wide enough for 640x480 plus margin
    typedef logic [9:0] coord_t;

    // one decimal digit of a counter
    typedef logic [3:0] bcd_t;

    // 4 bits per channel, red in the top nibble
    typedef logic [11:0] rgb_t;

    // rom address is char code over row index
    typedef logic [10:0] glyph_addr_t;

    // one glyph row, bit 7 is the leftmost column
    typedef logic [7:0] glyph_row_t;

    // pixel position as it comes from the sync generator
    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   video_on;
    } pixel_t;

    // everything the scoreboard shows as digits
    typedef struct packed {
        bcd_t min_10s;
        bcd_t min_1s;
        bcd_t sec_10s;
        bcd_t sec_1s;
        bcd_t player_10s;
        bcd_t player_1s;
    } time_digits_t;

    // per-layer hit flags, one pipeline stage after the pixel
    typedef struct packed {
        logic       digit_field;
        logic       digit_bit;
        logic [2:0] circle_hit;
        logic       banner_hit;
        logic       video_on;
    } layer_hits_t;

    // palette
    localparam rgb_t COLOR_DIGIT    = 12'hF80;
    localparam rgb_t COLOR_BACKDROP = 12'h222;
    localparam rgb_t COLOR_BLANK    = 12'h000;
    localparam rgb_t COLOR_WHITE    = 12'hFFF;
    localparam rgb_t COLOR_RED      = 12'hF00;

    // ascii codes for the font rom
    localparam logic [6:0] DIGIT_CODE_BASE = 7'h30;
    localparam logic [6:0] COLON_CODE      = 7'h3A;

endpackage

//--- src/layout_pkg.sv
package layout_pkg;

    // clock digits, all fields 32 wide and 64 tall
    localparam display_pkg::coord_t DIGIT_Y_TOP    = 10'd192;
    localparam display_pkg::coord_t DIGIT_Y_BOTTOM = 10'd255;

    // left edges, player counter sits left of the clock
    localparam display_pkg::coord_t PLAYER_10S_X = 10'd160;
    localparam display_pkg::coord_t PLAYER_1S_X  = 10'd192;
    localparam display_pkg::coord_t MIN_10S_X    = 10'd256;
    localparam display_pkg::coord_t MIN_1S_X     = 10'd288;
    localparam display_pkg::coord_t COLON_X      = 10'd320;
    localparam display_pkg::coord_t SEC_10S_X    = 10'd352;
    localparam display_pkg::coord_t SEC_1S_X     = 10'd384;

    // sensor indicators, one row of three
    localparam int CIRCLE_COUNT  = 3;
    localparam int CIRCLE_RADIUS = 50;
    localparam display_pkg::coord_t CIRCLE_Y = 10'd350;
    // index 0 is the rightmost circle
    localparam display_pkg::coord_t CIRCLE_X [CIRCLE_COUNT] = '{10'd450, 10'd300, 10'd150};

    // inclusive rectangle
    typedef struct packed {
        display_pkg::coord_t x_lo;
        display_pkg::coord_t x_hi;
        display_pkg::coord_t y_lo;
        display_pkg::coord_t y_hi;
    } banner_box_t;

    // frame bars plus the strokes of S, C, O, R and E
    localparam int BANNER_BOXES = 25;
    localparam banner_box_t BANNER_RECT [BANNER_BOXES] = '{
        // frame, left, right, top, bottom
        '{10'd0,   10'd20,  10'd0,   10'd500},
        '{10'd620, 10'd639, 10'd0,   10'd500},
        '{10'd20,  10'd620, 10'd0,   10'd20},
        '{10'd20,  10'd620, 10'd480, 10'd500},
        // S
        '{10'd65,  10'd85,  10'd120, 10'd130},
        '{10'd65,  10'd85,  10'd150, 10'd160},
        '{10'd65,  10'd70,  10'd130, 10'd140},
        '{10'd70,  10'd80,  10'd135, 10'd140},
        '{10'd80,  10'd85,  10'd135, 10'd150},
        // C
        '{10'd100, 10'd105, 10'd120, 10'd160},
        '{10'd105, 10'd115, 10'd120, 10'd130},
        '{10'd105, 10'd115, 10'd150, 10'd160},
        // O
        '{10'd130, 10'd135, 10'd120, 10'd160},
        '{10'd135, 10'd145, 10'd120, 10'd130},
        '{10'd145, 10'd150, 10'd120, 10'd160},
        '{10'd135, 10'd145, 10'd150, 10'd160},
        // R
        '{10'd160, 10'd180, 10'd120, 10'd130},
        '{10'd160, 10'd165, 10'd130, 10'd160},
        '{10'd175, 10'd180, 10'd130, 10'd145},
        '{10'd175, 10'd180, 10'd150, 10'd160},
        '{10'd160, 10'd175, 10'd145, 10'd150},
        // E
        '{10'd195, 10'd200, 10'd120, 10'd160},
        '{10'd200, 10'd210, 10'd120, 10'd130},
        '{10'd200, 10'd205, 10'd135, 10'd145},
        '{10'd200, 10'd210, 10'd150, 10'd160}
    };

endpackage

//--- src/font_rom.sv
module font_rom (
    input  logic        clk,
    input  logic [10:0] addr,
    output logic [7:0]  data
);

    // digits 0-9 and the colon, 16 rows each
    localparam int GLYPHS = 11;
    localparam int ROWS   = 16;

    logic [7:0] rom [GLYPHS*ROWS];
    logic       in_range;

    initial begin
        $readmemh("src/font_digits.hex", rom);
    end

    // codes 30h..3Ah, so the low nibble of the code is the glyph number
    assign in_range = (addr[10:8] == 3'b011) && (addr[7:4] <= 4'd10);

    // one cycle read, anything else reads blank
    always_ff @(posedge clk) begin
        if (in_range) begin
            data <= rom[addr[7:0]];
        end else begin
            data <= '0;
        end
    end

endmodule

//--- src/digit_overlay.sv
module digit_overlay (
    input  logic                      clk,
    input  logic                      rst,
    input  display_pkg::pixel_t       pixel,
    input  display_pkg::time_digits_t digits,
    output logic                      field_hit,
    output logic                      glyph_bit
);

    logic                     in_rows;
    logic                     field_now;
    logic [6:0]               char_code;
    display_pkg::glyph_addr_t rom_addr;
    display_pkg::glyph_row_t  rom_word;
    logic                     field_q;
    logic [2:0]               col_q;

    // 32 wide field starting at left
    function automatic logic in_column(input display_pkg::coord_t x,
                                       input display_pkg::coord_t left);
        return (x >= left) && (x <= left + 10'd31);
    endfunction

    // ascii code of a bcd digit
    function automatic logic [6:0] digit_code(input display_pkg::bcd_t d);
        return display_pkg::DIGIT_CODE_BASE + {3'b000, d};
    endfunction

    // field decode, code 0 outside every field so the rom reads blank
    always_comb begin
        in_rows   = (pixel.y >= layout_pkg::DIGIT_Y_TOP) &&
                    (pixel.y <= layout_pkg::DIGIT_Y_BOTTOM);
        field_now = in_rows;
        char_code = '0;
        if (!in_rows) begin
            field_now = 1'b0;
        end else if (in_column(pixel.x, layout_pkg::PLAYER_10S_X)) begin
            char_code = digit_code(digits.player_10s);
        end else if (in_column(pixel.x, layout_pkg::PLAYER_1S_X)) begin
            char_code = digit_code(digits.player_1s);
        end else if (in_column(pixel.x, layout_pkg::MIN_10S_X)) begin
            char_code = digit_code(digits.min_10s);
        end else if (in_column(pixel.x, layout_pkg::MIN_1S_X)) begin
            char_code = digit_code(digits.min_1s);
        end else if (in_column(pixel.x, layout_pkg::COLON_X)) begin
            char_code = display_pkg::COLON_CODE;
        end else if (in_column(pixel.x, layout_pkg::SEC_10S_X)) begin
            char_code = digit_code(digits.sec_10s);
        end else if (in_column(pixel.x, layout_pkg::SEC_1S_X)) begin
            char_code = digit_code(digits.sec_1s);
        end else begin
            field_now = 1'b0;
        end
    end

    // 8x16 glyph scaled by 4, row from y[5:2]
    assign rom_addr = {char_code, pixel.y[5:2]};

    font_rom u_font_rom (
        .clk  (clk),
        .addr (rom_addr),
        .data (rom_word)
    );

    // hold flag and column until the rom word arrives
    always_ff @(posedge clk) begin
        if (rst) begin
            field_q <= 1'b0;
            col_q   <= '0;
        end else begin
            field_q <= field_now;
            col_q   <= pixel.x[4:2];
        end
    end

    assign field_hit = field_q;
    // msb is the left column
    assign glyph_bit = field_q & rom_word[3'd7 - col_q];

endmodule

//--- src/circle_indicators.sv
module circle_indicators (
    input  logic                clk,
    input  logic                rst,
    input  display_pkg::pixel_t pixel,
    output logic [2:0]          circle_hit
);

    // radius squared in the width of the distance sum
    localparam logic [21:0] RADIUS_SQ =
        22'(layout_pkg::CIRCLE_RADIUS * layout_pkg::CIRCLE_RADIUS);

    logic [2:0] hit_now;

    for (genvar i = 0; i < layout_pkg::CIRCLE_COUNT; i++) begin : g_circle
        logic signed [10:0] dx;
        logic signed [10:0] dy;
        logic signed [21:0] dx_sq;
        logic signed [21:0] dy_sq;
        logic [21:0]        dist_sq;

        // signed offsets, no wrap near the screen edge
        always_comb begin
            dx      = $signed({1'b0, pixel.x}) - $signed({1'b0, layout_pkg::CIRCLE_X[i]});
            dy      = $signed({1'b0, pixel.y}) - $signed({1'b0, layout_pkg::CIRCLE_Y});
            dx_sq   = dx * dx;
            dy_sq   = dy * dy;
            // never negative, fits in 21 bits
            dist_sq = dx_sq + dy_sq;
        end

        // edge point at exactly the radius counts as inside
        assign hit_now[i] = (dist_sq <= RADIUS_SQ);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            circle_hit <= '0;
        end else begin
            circle_hit <= hit_now;
        end
    end

endmodule

//--- src/score_banner.sv
module score_banner (
    input  logic                clk,
    input  logic                rst,
    input  display_pkg::pixel_t pixel,
    output logic                banner_hit
);

    logic hit_now;

    // OR of all inclusive box tests
    always_comb begin
        hit_now = 1'b0;
        for (int i = 0; i < layout_pkg::BANNER_BOXES; i++) begin
            if ((pixel.x >= layout_pkg::BANNER_RECT[i].x_lo) &&
                (pixel.x <= layout_pkg::BANNER_RECT[i].x_hi) &&
                (pixel.y >= layout_pkg::BANNER_RECT[i].y_lo) &&
                (pixel.y <= layout_pkg::BANNER_RECT[i].y_hi)) begin
                hit_now = 1'b1;
            end
        end
    end

    // lines up with the rom read in digit_overlay
    always_ff @(posedge clk) begin
        if (rst) begin
            banner_hit <= 1'b0;
        end else begin
            banner_hit <= hit_now;
        end
    end

endmodule

//--- src/layer_priority.sv
module layer_priority (
    input  logic                     clk,
    input  logic                     rst,
    input  display_pkg::layer_hits_t hits,
    input  logic [2:0]               sensors,
    output display_pkg::rgb_t        time_rgb
);

    display_pkg::rgb_t circle_rgb;
    display_pkg::rgb_t rgb_next;

    // lowest circle index wins, so walk down and let the last hit stick
    always_comb begin
        circle_rgb = display_pkg::COLOR_BLANK;
        for (int i = layout_pkg::CIRCLE_COUNT - 1; i >= 0; i--) begin
            if (hits.circle_hit[i]) begin
                // sensor high means clear, low means blocked
                circle_rgb = sensors[i] ? display_pkg::COLOR_WHITE : display_pkg::COLOR_RED;
            end
        end
    end

    // digits win even in blanking
    always_comb begin
        if (hits.digit_field) begin
            rgb_next = hits.digit_bit ? display_pkg::COLOR_DIGIT : display_pkg::COLOR_BACKDROP;
        end else if (!hits.video_on) begin
            rgb_next = display_pkg::COLOR_BACKDROP;
        end else if (|hits.circle_hit) begin
            rgb_next = circle_rgb;
        end else if (hits.banner_hit) begin
            rgb_next = display_pkg::COLOR_WHITE;
        end else begin
            rgb_next = display_pkg::COLOR_BLANK;
        end
    end

    // second pipeline stage
    always_ff @(posedge clk) begin
        if (rst) begin
            time_rgb <= display_pkg::COLOR_BLANK;
        end else begin
            time_rgb <= rgb_next;
        end
    end

endmodule

//--- src/scoreboard_pixel_top.sv
module scoreboard_pixel_top (
    input  logic                      clk,
    input  logic                      rst,
    input  display_pkg::pixel_t       pixel,
    input  display_pkg::time_digits_t digits,
    input  logic [2:0]                ir_sensor,
    output display_pkg::rgb_t         time_rgb
);

    logic                     field_hit;
    logic                     glyph_bit;
    logic [2:0]               circle_hit;
    logic                     banner_hit;
    logic                     video_on_q;
    logic [2:0]               sensor_q;
    display_pkg::layer_hits_t hits;

    // stage 1, all three layers look at the same pixel
    digit_overlay u_digit_overlay (
        .clk       (clk),
        .rst       (rst),
        .pixel     (pixel),
        .digits    (digits),
        .field_hit (field_hit),
        .glyph_bit (glyph_bit)
    );

    circle_indicators u_circle_indicators (
        .clk        (clk),
        .rst        (rst),
        .pixel      (pixel),
        .circle_hit (circle_hit)
    );

    score_banner u_score_banner (
        .clk        (clk),
        .rst        (rst),
        .pixel      (pixel),
        .banner_hit (banner_hit)
    );

    // blanking and sensors travel with the pixel
    always_ff @(posedge clk) begin
        if (rst) begin
            video_on_q <= 1'b0;
            sensor_q   <= '0;
        end else begin
            video_on_q <= pixel.video_on;
            sensor_q   <= ir_sensor;
        end
    end

    always_comb begin
        hits.digit_field = field_hit;
        hits.digit_bit   = glyph_bit;
        hits.circle_hit  = circle_hit;
        hits.banner_hit  = banner_hit;
        hits.video_on    = video_on_q;
    end

    // stage 2, final colour
    layer_priority u_layer_priority (
        .clk      (clk),
        .rst      (rst),
        .hits     (hits),
        .sensors  (sensor_q),
        .time_rgb (time_rgb)
    );

endmodule

//--- testbench/scoreboard_pixel_props.sv
module scoreboard_pixel_props (
    input logic              clk,
    input logic              rst,
    input display_pkg::rgb_t time_rgb,
    input logic              field_hit,
    input logic              glyph_bit
);

    // output black on every cycle that follows a reset edge
    assert property (@(posedge clk) rst |=> (time_rgb == 12'h000))
        else $error("time_rgb not black after a reset cycle");

    // palette has five entries, nothing else may leave the pipeline
    assert property (@(posedge clk) disable iff (rst)
        (time_rgb == 12'hF80) || (time_rgb == 12'h222) || (time_rgb == 12'h000) ||
        (time_rgb == 12'hFFF) || (time_rgb == 12'hF00))
        else $error("time_rgb %h is not a palette colour", time_rgb);

    // digit field colour follows the glyph bit one stage later
    assert property (@(posedge clk) disable iff (rst)
        field_hit |=> (time_rgb == ($past(glyph_bit) ? 12'hF80 : 12'h222)))
        else $error("time_rgb %h does not follow the glyph bit", time_rgb);

endmodule

// field_hit and glyph_bit are visible as nets in the top level
bind scoreboard_pixel_top scoreboard_pixel_props u_props (
    .clk       (clk),
    .rst       (rst),
    .time_rgb  (time_rgb),
    .field_hit (field_hit),
    .glyph_bit (glyph_bit)
);

//--- testbench/tb_scoreboard_pixel.sv
module tb_scoreboard_pixel;

    localparam int RANDOM_PIXELS = 2000;

    // one table row, expected colour is ignored when use_model is set
    typedef struct packed {
        display_pkg::pixel_t       pixel;
        display_pkg::time_digits_t digits;
        logic [2:0]                sensors;
        logic                      use_model;
        display_pkg::rgb_t         expected;
    } stim_t;

    logic                      clk;
    logic                      rst;
    display_pkg::pixel_t       pixel;
    display_pkg::time_digits_t digits;
    logic [2:0]                ir_sensor;
    display_pkg::rgb_t         time_rgb;

    logic [7:0]        font [176];
    stim_t             table_q [$];
    display_pkg::rgb_t expect_q [$];
    string             tag_q [$];
    int                seed;
    int                cycles;
    int                cycle_limit;

    scoreboard_pixel_top u_scoreboard_pixel_top (
        .clk       (clk),
        .rst       (rst),
        .pixel     (pixel),
        .digits    (digits),
        .ir_sensor (ir_sensor),
        .time_rgb  (time_rgb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic check_rgb(input display_pkg::rgb_t actual, input display_pkg::rgb_t expected,
                             input string tag);
        if (actual !== expected) begin
            $display("FAILED time_rgb (%s): got %h expected %h", tag, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic add_entry(input int x, input int y, input logic vo, input logic [23:0] dig,
                             input logic [2:0] sens, input logic [11:0] rgb, input logic model);
        stim_t s;
        s = '0;
        s.pixel.x        = 10'(x);
        s.pixel.y        = 10'(y);
        s.pixel.video_on = vo;
        s.digits         = dig;
        s.sensors        = sens;
        s.use_model      = model;
        s.expected       = rgb;
        table_q.push_back(s);
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // colour rule straight from the layout, glyph rows from the font file
    function automatic display_pkg::rgb_t model_rgb(input display_pkg::pixel_t p,
                                                    input display_pkg::time_digits_t d,
                                                    input logic [2:0] sens);
        int         x;
        int         y;
        int         dx;
        int         dy;
        int         left [7];
        int         glyph [7];
        logic [7:0] font_addr;
        logic [7:0] row_bits;
        x = int'(p.x);
        y = int'(p.y);
        left = '{int'(layout_pkg::PLAYER_10S_X), int'(layout_pkg::PLAYER_1S_X),
                 int'(layout_pkg::MIN_10S_X), int'(layout_pkg::MIN_1S_X),
                 int'(layout_pkg::COLON_X), int'(layout_pkg::SEC_10S_X),
                 int'(layout_pkg::SEC_1S_X)};
        // glyph 10 is the colon
        glyph = '{int'(d.player_10s), int'(d.player_1s), int'(d.min_10s), int'(d.min_1s),
                  10, int'(d.sec_10s), int'(d.sec_1s)};
        // digits win even in blanking
        if (y >= int'(layout_pkg::DIGIT_Y_TOP) && y <= int'(layout_pkg::DIGIT_Y_BOTTOM)) begin
            for (int f = 0; f < 7; f++) begin
                if (x >= left[f] && x < left[f] + 32) begin
                    // 8x16 glyph scaled by 4
                    font_addr = 8'(glyph[f] * 16 + ((y >> 2) & 15));
                    row_bits  = font[font_addr];
                    return row_bits[3'(7 - ((x >> 2) & 7))] ? 12'hF80 : 12'h222;
                end
            end
        end
        if (!p.video_on) begin
            return 12'h222;
        end
        // first circle that holds the pixel decides
        for (int i = 0; i < 3; i++) begin
            dx = x - int'(layout_pkg::CIRCLE_X[i]);
            dy = y - int'(layout_pkg::CIRCLE_Y);
            if (dx * dx + dy * dy <= layout_pkg::CIRCLE_RADIUS * layout_pkg::CIRCLE_RADIUS) begin
                return sens[i] ? 12'hFFF : 12'hF00;
            end
        end
        for (int b = 0; b < layout_pkg::BANNER_BOXES; b++) begin
            if (x >= int'(layout_pkg::BANNER_RECT[b].x_lo) &&
                x <= int'(layout_pkg::BANNER_RECT[b].x_hi) &&
                y >= int'(layout_pkg::BANNER_RECT[b].y_lo) &&
                y <= int'(layout_pkg::BANNER_RECT[b].y_hi)) begin
                return 12'hFFF;
            end
        end
        return 12'h000;
    endfunction

    function automatic stim_t random_stim();
        stim_t       s;
        logic [23:0] dig;
        s   = '0;
        dig = '0;
        s.pixel.x        = 10'(rand_below(640));
        s.pixel.y        = 10'(rand_below(480));
        s.pixel.video_on = 1'(rand_below(2));
        // valid bcd only
        for (int k = 0; k < 6; k++) begin
            dig = {dig[19:0], 4'(rand_below(10))};
        end
        s.digits    = dig;
        s.sensors   = 3'(rand_below(8));
        s.use_model = 1'b1;
        return s;
    endfunction

    // layers alternate so neighbours in the pipeline differ
    task automatic build_table();
        add_entry(450, 350, 1'b1, 24'h123456, 3'b001, 12'hFFF, 1'b0);
        add_entry(172, 210, 1'b1, 24'h123456, 3'b000, 12'h000, 1'b1);
        add_entry(10, 240, 1'b1, 24'h123456, 3'b000, 12'hFFF, 1'b0);
        add_entry(450, 350, 1'b1, 24'h123456, 3'b110, 12'hF00, 1'b0);
        add_entry(208, 220, 1'b1, 24'h123456, 3'b000, 12'h000, 1'b1);
        add_entry(21, 240, 1'b1, 24'h123456, 3'b000, 12'h000, 1'b0);
        add_entry(300, 350, 1'b1, 24'h123456, 3'b010, 12'hFFF, 1'b0);
        add_entry(268, 200, 1'b1, 24'h123456, 3'b000, 12'hF80, 1'b0);
        add_entry(21, 240, 1'b0, 24'h123456, 3'b000, 12'h222, 1'b0);
        add_entry(300, 350, 1'b1, 24'h123456, 3'b101, 12'hF00, 1'b0);
        add_entry(296, 216, 1'b1, 24'h123456, 3'b000, 12'h000, 1'b1);
        add_entry(320, 20, 1'b1, 24'h123456, 3'b000, 12'hFFF, 1'b0);
        add_entry(150, 350, 1'b1, 24'h123456, 3'b100, 12'hFFF, 1'b0);
        add_entry(334, 212, 1'b1, 24'h123456, 3'b000, 12'h000, 1'b1);
        add_entry(70, 125, 1'b1, 24'h123456, 3'b000, 12'hFFF, 1'b0);
        add_entry(150, 350, 1'b1, 24'h123456, 3'b011, 12'hF00, 1'b0);
        add_entry(322, 212, 1'b1, 24'h123456, 3'b000, 12'h000, 1'b1);
        add_entry(147, 140, 1'b1, 24'h123456, 3'b000, 12'hFFF, 1'b0);
        add_entry(500, 350, 1'b1, 24'h123456, 3'b001, 12'hFFF, 1'b0);
        add_entry(256, 200, 1'b1, 24'h123456, 3'b000, 12'h222, 1'b0);
        add_entry(501, 350, 1'b1, 24'h123456, 3'b001, 12'h000, 1'b0);
        add_entry(376, 250, 1'b1, 24'h123456, 3'b000, 12'h000, 1'b1);
        add_entry(140, 140, 1'b1, 24'h123456, 3'b000, 12'h000, 1'b0);
        add_entry(450, 300, 1'b1, 24'h123456, 3'b000, 12'hF00, 1'b0);
        add_entry(388, 224, 1'b1, 24'h123456, 3'b000, 12'h000, 1'b1);
        add_entry(207, 140, 1'b1, 24'h123456, 3'b000, 12'h000, 1'b0);
        add_entry(450, 299, 1'b1, 24'h123456, 3'b111, 12'h000, 1'b0);
        add_entry(172, 210, 1'b0, 24'h123456, 3'b000, 12'h000, 1'b1);
        add_entry(10, 240, 1'b0, 24'h123456, 3'b000, 12'h222, 1'b0);
        add_entry(450, 350, 1'b0, 24'h123456, 3'b111, 12'h222, 1'b0);
        add_entry(334, 212, 1'b0, 24'h123456, 3'b000, 12'h000, 1'b1);
        add_entry(296, 216, 1'b1, 24'h987012, 3'b000, 12'h000, 1'b1);
    endtask

    task automatic check_oldest();
        check_rgb(time_rgb, expect_q.pop_front(), tag_q.pop_front());
    endtask

    task automatic apply_pixel(input stim_t s, input string tag);
        display_pkg::rgb_t exp;
        @(posedge clk);
        pixel     <= s.pixel;
        digits    <= s.digits;
        ir_sensor <= s.sensors;
        exp = s.use_model ? model_rgb(s.pixel, s.digits, s.sensors) : s.expected;
        expect_q.push_back(exp);
        tag_q.push_back(tag);
        @(negedge clk);
        // the pixel from two edges back is at the output now
        if (expect_q.size() > 2) begin
            check_oldest();
        end
    endtask

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > cycle_limit) begin
                $display("timeout: run did not finish within %0d cycles", cycle_limit);
                stop_with_failure();
            end
        end
    end

    initial begin
        seed        = 32'ha28e;
        rst         = 1'b1;
        pixel       = '0;
        digits      = '0;
        ir_sensor   = '0;
        $readmemh("src/font_digits.hex", font);
        build_table();
        cycle_limit = table_q.size() + RANDOM_PIXELS + 20;
        // black while reset is held
        @(posedge clk);
        @(negedge clk);
        check_rgb(time_rgb, 12'h000, "reset cycle 1");
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_rgb(time_rgb, 12'h000, "reset cycle 2");
        foreach (table_q[i]) begin
            apply_pixel(table_q[i], $sformatf("table entry %0d", i));
        end
        for (int n = 0; n < RANDOM_PIXELS; n++) begin
            apply_pixel(random_stim(), $sformatf("random pixel %0d", n));
        end
        // two pixels still in flight
        while (expect_q.size() > 0) begin
            @(posedge clk);
            @(negedge clk);
            check_oldest();
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- src/font_digits.hex
// one glyph per line, sixteen row bytes with the top row first, bit 7 is the left column
// lines are the glyphs for 0 to 9, then the colon
00 00 7C C6 C6 CE DE F6 E6 C6 C6 7C 00 00 00 00
00 00 18 38 78 18 18 18 18 18 18 7E 00 00 00 00
00 00 7C C6 06 0C 18 30 60 C0 C6 FE 00 00 00 00
00 00 7C C6 06 06 3C 06 06 06 C6 7C 00 00 00 00
00 00 0C 1C 3C 6C CC FE 0C 0C 0C 1E 00 00 00 00
00 00 FE C0 C0 C0 FC 06 06 06 C6 7C 00 00 00 00
00 00 38 60 C0 C0 FC C6 C6 C6 C6 7C 00 00 00 00
00 00 FE C6 06 06 0C 18 30 30 30 30 00 00 00 00
00 00 7C C6 C6 C6 7C C6 C6 C6 C6 7C 00 00 00 00
00 00 7C C6 C6 C6 7E 06 06 06 0C 78 00 00 00 00
00 00 00 00 18 18 00 00 00 18 18 00 00 00 00 00

//--- build.f
src/display_pkg.sv
src/layout_pkg.sv
src/font_rom.sv
src/digit_overlay.sv
src/circle_indicators.sv
src/score_banner.sv
src/layer_priority.sv
src/scoreboard_pixel_top.sv
testbench/scoreboard_pixel_props.sv
testbench/tb_scoreboard_pixel.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_scoreboard_pixel
FLAGS     ?= --binary --assert -j 0
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
